//--- include/backend_consts.svh
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// datapath width
`define BE_XLEN         32

// register counts
`define BE_ARCH_REGS    8
`define BE_PHYS_REGS    16
`define BE_FREE_REGS    (`BE_PHYS_REGS - `BE_ARCH_REGS)

// buffer depths
`define BE_ROB_DEPTH    8
`define BE_RS_DEPTH     4

// index widths that go with the sizes above
`define BE_ARCH_IDX_W   3
`define BE_PHYS_IDX_W   4
`define BE_ROB_IDX_W    3
`define BE_RS_IDX_W     2
`define BE_FREE_IDX_W   3

`endif

//--- design/uop_pkg.sv
`include "backend_consts.svh"

package uop_pkg;

    typedef logic [`BE_XLEN-1:0] xlen_t;

    // shifts take the low 5 bits of operand b and slt compares signed
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

endpackage

//--- design/rename_pkg.sv
`include "backend_consts.svh"

package rename_pkg;

    typedef logic [`BE_ARCH_IDX_W-1:0] arch_idx_t;
    typedef logic [`BE_PHYS_IDX_W-1:0] phys_idx_t;
    typedef logic [`BE_ROB_IDX_W-1:0]  rob_idx_t;
    typedef logic [`BE_ROB_IDX_W:0]    rob_cnt_t;
    typedef logic [`BE_RS_IDX_W-1:0]   rs_idx_t;

    // station entry lifetime
    typedef enum logic [1:0] {
        RS_FREE    = 2'd0,
        RS_WAITING = 2'd1,
        RS_READY   = 2'd2
    } rs_state_e;

endpackage

//--- design/rename_stage.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

module rename_stage (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  uop_valid_i,
    output logic                  uop_ready_o,
    input  uop_pkg::alu_op_e      uop_op_i,
    input  rename_pkg::arch_idx_t uop_rd_i,
    input  rename_pkg::arch_idx_t uop_rs1_i,
    input  rename_pkg::arch_idx_t uop_rs2_i,
    input  uop_pkg::xlen_t        uop_imm_i,
    input  logic                  uop_use_imm_i,
    input  logic                  rob_full_i,
    input  logic                  rs_full_i,
    input  logic                  free_valid_i,
    input  rename_pkg::phys_idx_t free_pd_i,
    output logic                  disp_valid_o,
    output uop_pkg::alu_op_e      disp_op_o,
    output rename_pkg::arch_idx_t disp_rd_o,
    output rename_pkg::phys_idx_t disp_pd_o,
    output rename_pkg::phys_idx_t disp_old_pd_o,
    output rename_pkg::phys_idx_t disp_ps1_o,
    output rename_pkg::phys_idx_t disp_ps2_o,
    output uop_pkg::xlen_t        disp_imm_o,
    output logic                  disp_use_imm_o
);
    import rename_pkg::*;

    phys_idx_t                  rat   [`BE_ARCH_REGS];

    phys_idx_t                  fl_mem[`BE_FREE_REGS];
    logic [`BE_FREE_IDX_W-1:0]  fl_head;
    logic [`BE_FREE_IDX_W-1:0]  fl_tail;
    logic [`BE_FREE_IDX_W:0]    fl_count;

    logic                       accept;
    phys_idx_t                  new_pd;

    assign uop_ready_o = (fl_count != '0) && !rob_full_i && !rs_full_i;
    assign accept      = uop_valid_i && uop_ready_o;
    assign new_pd      = fl_mem[fl_head];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alias table and free list
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BE_ARCH_REGS; i++) begin
                rat[i] <= phys_idx_t'(i);
            end
            for (int i = 0; i < `BE_FREE_REGS; i++) begin
                fl_mem[i] <= phys_idx_t'(`BE_ARCH_REGS + i);
            end
            fl_head      <= '0;
            fl_tail      <= '0;
            fl_count     <= (`BE_FREE_IDX_W+1)'(`BE_FREE_REGS);
            disp_valid_o <= 1'b0;
        end else begin
            disp_valid_o <= accept;
            if (accept) begin
                rat[uop_rd_i] <= new_pd;
                fl_head       <= fl_head + 1'b1;
            end
            // a retired instruction frees the register its destination used to map to
            if (free_valid_i) begin
                fl_mem[fl_tail] <= free_pd_i;
                fl_tail         <= fl_tail + 1'b1;
            end
            if (accept && !free_valid_i) begin
                fl_count <= fl_count - 1'b1;
            end else if (!accept && free_valid_i) begin
                fl_count <= fl_count + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // dispatch register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (accept) begin
            disp_op_o      <= uop_op_i;
            disp_rd_o      <= uop_rd_i;
            disp_pd_o      <= new_pd;
            disp_old_pd_o  <= rat[uop_rd_i];
            disp_ps1_o     <= rat[uop_rs1_i];
            disp_ps2_o     <= rat[uop_rs2_i];
            disp_imm_o     <= uop_imm_i;
            disp_use_imm_o <= uop_use_imm_i;
        end
    end

endmodule

//--- design/rob.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

module rob (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  disp_valid_i,
    input  rename_pkg::arch_idx_t disp_rd_i,
    input  rename_pkg::phys_idx_t disp_old_pd_i,
    output rename_pkg::rob_idx_t  rob_tail_o,
    output logic                  rob_full_o,
    input  logic                  cdb_valid_i,
    input  rename_pkg::rob_idx_t  cdb_rob_i,
    input  uop_pkg::xlen_t        cdb_value_i,
    output logic                  commit_valid_o,
    output rename_pkg::arch_idx_t commit_rd_o,
    output uop_pkg::xlen_t        commit_value_o,
    output logic                  free_valid_o,
    output rename_pkg::phys_idx_t free_pd_o
);
    import uop_pkg::*;
    import rename_pkg::*;

    logic [`BE_ROB_DEPTH-1:0]   done_q;
    xlen_t                      value_q [`BE_ROB_DEPTH];
    arch_idx_t                  rd_q    [`BE_ROB_DEPTH];
    phys_idx_t                  old_pd_q[`BE_ROB_DEPTH];

    rob_idx_t                   head_q;
    rob_idx_t                   tail_q;
    rob_cnt_t                   rob_count;

    logic                       head_cdb;
    logic                       retire;
    xlen_t                      head_value;

    // the head can retire in the same cycle its result is on the CDB
    assign head_cdb   = cdb_valid_i && (cdb_rob_i == head_q);
    assign retire     = (rob_count != '0) && (done_q[head_q] || head_cdb);
    assign head_value = head_cdb ? cdb_value_i : value_q[head_q];

    assign rob_tail_o = tail_q;
    // one dispatch may already be in flight from the rename register
    assign rob_full_o = rob_count >= rob_cnt_t'(`BE_ROB_DEPTH - 1);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q         <= '0;
            head_q         <= '0;
            tail_q         <= '0;
            rob_count      <= '0;
            commit_valid_o <= 1'b0;
            commit_rd_o    <= '0;
            commit_value_o <= '0;
            free_valid_o   <= 1'b0;
            free_pd_o      <= '0;
        end else begin
            if (disp_valid_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (cdb_valid_i) begin
                done_q[cdb_rob_i] <= 1'b1;
            end
            if (disp_valid_i && !retire) begin
                rob_count <= rob_count + 1'b1;
            end else if (!disp_valid_i && retire) begin
                rob_count <= rob_count - 1'b1;
            end

            commit_valid_o <= retire;
            free_valid_o   <= retire;
            if (retire) begin
                head_q         <= head_q + 1'b1;
                commit_rd_o    <= rd_q[head_q];
                commit_value_o <= head_value;
                free_pd_o      <= old_pd_q[head_q];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid_i) begin
            rd_q[tail_q]     <= disp_rd_i;
            old_pd_q[tail_q] <= disp_old_pd_i;
        end
        if (cdb_valid_i) begin
            value_q[cdb_rob_i] <= cdb_value_i;
        end
    end

endmodule

//--- design/int_rs.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

module int_rs (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  disp_valid_i,
    input  uop_pkg::alu_op_e      disp_op_i,
    input  rename_pkg::phys_idx_t disp_pd_i,
    input  rename_pkg::phys_idx_t disp_ps1_i,
    input  rename_pkg::phys_idx_t disp_ps2_i,
    input  uop_pkg::xlen_t        disp_imm_i,
    input  logic                  disp_use_imm_i,
    input  rename_pkg::rob_idx_t  rob_tail_i,
    input  uop_pkg::xlen_t        rs1_value_i,
    input  logic                  rs1_ready_i,
    input  uop_pkg::xlen_t        rs2_value_i,
    input  logic                  rs2_ready_i,
    output logic                  rs_full_o,
    output logic                  cdb_valid_o,
    output rename_pkg::phys_idx_t cdb_pd_o,
    output rename_pkg::rob_idx_t  cdb_rob_o,
    output uop_pkg::xlen_t        cdb_value_o
);
    import uop_pkg::*;
    import rename_pkg::*;

    rs_state_e                  state_q[`BE_RS_DEPTH];
    alu_op_e                    op_q   [`BE_RS_DEPTH];
    phys_idx_t                  pd_q   [`BE_RS_DEPTH];
    phys_idx_t                  ps1_q  [`BE_RS_DEPTH];
    phys_idx_t                  ps2_q  [`BE_RS_DEPTH];
    rob_idx_t                   rob_q  [`BE_RS_DEPTH];
    xlen_t                      v1_q   [`BE_RS_DEPTH];
    xlen_t                      v2_q   [`BE_RS_DEPTH];
    // age counts the older entries still held, so the oldest has age zero
    rs_idx_t                    age_q  [`BE_RS_DEPTH];
    logic [`BE_RS_DEPTH-1:0]    rdy1_q;
    logic [`BE_RS_DEPTH-1:0]    rdy2_q;

    logic [`BE_RS_DEPTH-1:0]    wake1;
    logic [`BE_RS_DEPTH-1:0]    wake2;
    logic [`BE_RS_IDX_W:0]      free_cnt;
    rs_idx_t                    alloc_slot;
    rs_idx_t                    sel;
    logic                       issue;
    logic                       disp_r2;

    function automatic xlen_t alu_exec(input alu_op_e op, input xlen_t a, input xlen_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return xlen_t'($signed(a) < $signed(b));
            default: return '0;
        endcase
    endfunction

    // the register file already forwards a CDB write in the dispatch cycle
    assign disp_r2   = disp_use_imm_i || rs2_ready_i;
    assign rs_full_o = free_cnt <= 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wakeup, allocation and oldest-ready select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        free_cnt   = '0;
        alloc_slot = '0;
        issue      = 1'b0;
        sel        = '0;
        for (int i = 0; i < `BE_RS_DEPTH; i++) begin
            wake1[i] = (state_q[i] == RS_WAITING) && !rdy1_q[i] && cdb_valid_o
                       && (cdb_pd_o == ps1_q[i]);
            wake2[i] = (state_q[i] == RS_WAITING) && !rdy2_q[i] && cdb_valid_o
                       && (cdb_pd_o == ps2_q[i]);
            if (state_q[i] == RS_FREE) begin
                free_cnt   = free_cnt + 1'b1;
                alloc_slot = rs_idx_t'(i);
            end
            if (state_q[i] == RS_READY && (!issue || age_q[i] < age_q[sel])) begin
                issue = 1'b1;
                sel   = rs_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BE_RS_DEPTH; i++) begin
                state_q[i] <= RS_FREE;
                age_q[i]   <= '0;
            end
            rdy1_q      <= '0;
            rdy2_q      <= '0;
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= issue;
            for (int i = 0; i < `BE_RS_DEPTH; i++) begin
                if (issue && rs_idx_t'(i) == sel) begin
                    state_q[i] <= RS_FREE;
                end else if (state_q[i] == RS_WAITING) begin
                    rdy1_q[i] <= rdy1_q[i] || wake1[i];
                    rdy2_q[i] <= rdy2_q[i] || wake2[i];
                    if ((rdy1_q[i] || wake1[i]) && (rdy2_q[i] || wake2[i])) begin
                        state_q[i] <= RS_READY;
                    end
                end
                if (issue && state_q[i] != RS_FREE && age_q[i] > age_q[sel]) begin
                    age_q[i] <= age_q[i] - 1'b1;
                end
            end
            if (disp_valid_i) begin
                state_q[alloc_slot] <= (rs1_ready_i && disp_r2) ? RS_READY : RS_WAITING;
                rdy1_q[alloc_slot]  <= rs1_ready_i;
                rdy2_q[alloc_slot]  <= disp_r2;
                age_q[alloc_slot]   <= rs_idx_t'(`BE_RS_DEPTH - free_cnt - issue);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand capture and ALU stage onto the CDB
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        for (int i = 0; i < `BE_RS_DEPTH; i++) begin
            if (wake1[i]) begin
                v1_q[i] <= cdb_value_o;
            end
            if (wake2[i]) begin
                v2_q[i] <= cdb_value_o;
            end
        end
        if (disp_valid_i) begin
            op_q[alloc_slot]  <= disp_op_i;
            pd_q[alloc_slot]  <= disp_pd_i;
            ps1_q[alloc_slot] <= disp_ps1_i;
            ps2_q[alloc_slot] <= disp_ps2_i;
            rob_q[alloc_slot] <= rob_tail_i;
            v1_q[alloc_slot]  <= rs1_value_i;
            v2_q[alloc_slot]  <= disp_use_imm_i ? disp_imm_i : rs2_value_i;
        end
        if (issue) begin
            cdb_pd_o    <= pd_q[sel];
            cdb_rob_o   <= rob_q[sel];
            cdb_value_o <= alu_exec(op_q[sel], v1_q[sel], v2_q[sel]);
        end
    end

endmodule

//--- design/prf.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

module prf (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  alloc_valid_i,
    input  rename_pkg::phys_idx_t alloc_pd_i,
    input  rename_pkg::phys_idx_t rd1_pd_i,
    input  rename_pkg::phys_idx_t rd2_pd_i,
    output uop_pkg::xlen_t        rd1_value_o,
    output logic                  rd1_ready_o,
    output uop_pkg::xlen_t        rd2_value_o,
    output logic                  rd2_ready_o,
    input  logic                  cdb_valid_i,
    input  rename_pkg::phys_idx_t cdb_pd_i,
    input  uop_pkg::xlen_t        cdb_value_i
);
    import uop_pkg::*;

    xlen_t                      value_q[`BE_PHYS_REGS];
    logic [`BE_PHYS_REGS-1:0]   ready_q;
    logic                       fwd1;
    logic                       fwd2;

    assign fwd1        = cdb_valid_i && (cdb_pd_i == rd1_pd_i);
    assign fwd2        = cdb_valid_i && (cdb_pd_i == rd2_pd_i);
    assign rd1_value_o = fwd1 ? cdb_value_i : value_q[rd1_pd_i];
    assign rd2_value_o = fwd2 ? cdb_value_i : value_q[rd2_pd_i];
    assign rd1_ready_o = fwd1 || ready_q[rd1_pd_i];
    assign rd2_ready_o = fwd2 || ready_q[rd2_pd_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BE_PHYS_REGS; i++) begin
                value_q[i] <= '0;
            end
            ready_q <= '1;
        end else begin
            // a new destination waits until its producer broadcasts
            if (alloc_valid_i) begin
                ready_q[alloc_pd_i] <= 1'b0;
            end
            if (cdb_valid_i) begin
                value_q[cdb_pd_i] <= cdb_value_i;
                ready_q[cdb_pd_i] <= 1'b1;
            end
        end
    end

endmodule

//--- design/backend_top.sv
`timescale 1ns/1ps

module backend_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  uop_valid_i,
    output logic                  uop_ready_o,
    input  uop_pkg::alu_op_e      uop_op_i,
    input  rename_pkg::arch_idx_t uop_rd_i,
    input  rename_pkg::arch_idx_t uop_rs1_i,
    input  rename_pkg::arch_idx_t uop_rs2_i,
    input  uop_pkg::xlen_t        uop_imm_i,
    input  logic                  uop_use_imm_i,
    output logic                  commit_valid_o,
    output rename_pkg::arch_idx_t commit_rd_o,
    output uop_pkg::xlen_t        commit_value_o
);
    import uop_pkg::*;
    import rename_pkg::*;

    // dispatch bundle from the rename register
    logic       disp_valid;
    alu_op_e    disp_op;
    arch_idx_t  disp_rd;
    phys_idx_t  disp_pd;
    phys_idx_t  disp_old_pd;
    phys_idx_t  disp_ps1;
    phys_idx_t  disp_ps2;
    xlen_t      disp_imm;
    logic       disp_use_imm;

    logic       rob_full;
    logic       rs_full;
    rob_idx_t   rob_tail;
    xlen_t      rs1_value;
    logic       rs1_ready;
    xlen_t      rs2_value;
    logic       rs2_ready;

    logic       cdb_valid;
    phys_idx_t  cdb_pd;
    rob_idx_t   cdb_rob;
    xlen_t      cdb_value;

    logic       free_valid;
    phys_idx_t  free_pd;

    rename_stage rename_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .uop_valid_i    (uop_valid_i),
        .uop_ready_o    (uop_ready_o),
        .uop_op_i       (uop_op_i),
        .uop_rd_i       (uop_rd_i),
        .uop_rs1_i      (uop_rs1_i),
        .uop_rs2_i      (uop_rs2_i),
        .uop_imm_i      (uop_imm_i),
        .uop_use_imm_i  (uop_use_imm_i),
        .rob_full_i     (rob_full),
        .rs_full_i      (rs_full),
        .free_valid_i   (free_valid),
        .free_pd_i      (free_pd),
        .disp_valid_o   (disp_valid),
        .disp_op_o      (disp_op),
        .disp_rd_o      (disp_rd),
        .disp_pd_o      (disp_pd),
        .disp_old_pd_o  (disp_old_pd),
        .disp_ps1_o     (disp_ps1),
        .disp_ps2_o     (disp_ps2),
        .disp_imm_o     (disp_imm),
        .disp_use_imm_o (disp_use_imm)
    );

    rob rob_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .disp_valid_i   (disp_valid),
        .disp_rd_i      (disp_rd),
        .disp_old_pd_i  (disp_old_pd),
        .rob_tail_o     (rob_tail),
        .rob_full_o     (rob_full),
        .cdb_valid_i    (cdb_valid),
        .cdb_rob_i      (cdb_rob),
        .cdb_value_i    (cdb_value),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_value_o (commit_value_o),
        .free_valid_o   (free_valid),
        .free_pd_o      (free_pd)
    );

    int_rs int_rs_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .disp_valid_i   (disp_valid),
        .disp_op_i      (disp_op),
        .disp_pd_i      (disp_pd),
        .disp_ps1_i     (disp_ps1),
        .disp_ps2_i     (disp_ps2),
        .disp_imm_i     (disp_imm),
        .disp_use_imm_i (disp_use_imm),
        .rob_tail_i     (rob_tail),
        .rs1_value_i    (rs1_value),
        .rs1_ready_i    (rs1_ready),
        .rs2_value_i    (rs2_value),
        .rs2_ready_i    (rs2_ready),
        .rs_full_o      (rs_full),
        .cdb_valid_o    (cdb_valid),
        .cdb_pd_o       (cdb_pd),
        .cdb_rob_o      (cdb_rob),
        .cdb_value_o    (cdb_value)
    );

    prf prf_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .alloc_valid_i  (disp_valid),
        .alloc_pd_i     (disp_pd),
        .rd1_pd_i       (disp_ps1),
        .rd2_pd_i       (disp_ps2),
        .rd1_value_o    (rs1_value),
        .rd1_ready_o    (rs1_ready),
        .rd2_value_o    (rs2_value),
        .rd2_ready_o    (rs2_ready),
        .cdb_valid_i    (cdb_valid),
        .cdb_pd_i       (cdb_pd),
        .cdb_value_i    (cdb_value)
    );

endmodule

//--- sim/backend_checker.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

module backend_checker (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     uop_ready_i,
    input  logic                     commit_valid_i,
    input  rename_pkg::arch_idx_t    commit_rd_i,
    input  uop_pkg::xlen_t           commit_value_i,
    input  rename_pkg::rob_cnt_t     rob_count_i,
    input  logic [`BE_FREE_IDX_W:0]  fl_count_i
);
    import rename_pkg::*;

    // read by the testbench at the end of the run
    int fail_count = 0;

    commit_idle_in_reset: assert property (@(posedge clk) !rst_n_i |-> !commit_valid_i)
        else begin
            fail_count++;
            $error("commit_valid_o is high while reset is asserted");
        end

    commit_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown({commit_valid_i, commit_rd_i, commit_value_i}))
        else begin
            fail_count++;
            $error("commit outputs carry unknown bits after reset");
        end

    rob_bounded: assert property (@(posedge clk) disable iff (!rst_n_i)
        rob_count_i <= rob_cnt_t'(`BE_ROB_DEPTH))
        else begin
            fail_count++;
            $error("ROB count went past the buffer depth");
        end

    // an empty free list leaves nothing to rename into
    ready_needs_free: assert property (@(posedge clk) disable iff (!rst_n_i)
        (fl_count_i == '0) |-> !uop_ready_i)
        else begin
            fail_count++;
            $error("uop_ready_o is high with the free list empty");
        end

endmodule

//--- sim/backend_tb.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

module backend_tb;
    import uop_pkg::*;
    import rename_pkg::*;

    localparam int SEED           = 47;
    localparam int RANDOM_ROWS    = 40;
    localparam int MAX_ROWS       = 96;
    localparam int CYCLES_PER_ROW = 20;
    localparam int TIMEOUT_MARGIN = 200;
    localparam int BURST_ROWS     = `BE_ROB_DEPTH + 4;

    logic       clk = 1'b0;
    logic       rst_n_i;
    logic       uop_valid_i;
    logic       uop_ready_o;
    alu_op_e    uop_op_i;
    arch_idx_t  uop_rd_i;
    arch_idx_t  uop_rs1_i;
    arch_idx_t  uop_rs2_i;
    xlen_t      uop_imm_i;
    logic       uop_use_imm_i;
    logic       commit_valid_o;
    arch_idx_t  commit_rd_o;
    xlen_t      commit_value_o;

    // stimulus table, expected values filled in by the reference model
    alu_op_e    row_op     [MAX_ROWS];
    arch_idx_t  row_rd     [MAX_ROWS];
    arch_idx_t  row_rs1    [MAX_ROWS];
    arch_idx_t  row_rs2    [MAX_ROWS];
    xlen_t      row_imm    [MAX_ROWS];
    logic       row_use_imm[MAX_ROWS];
    int         row_gap    [MAX_ROWS];
    xlen_t      row_exp    [MAX_ROWS];
    int         n_rows;
    int         burst_lo;
    int         burst_hi;
    xlen_t      arch_regs  [`BE_ARCH_REGS];

    arch_idx_t  exp_rd_q [$];
    xlen_t      exp_val_q[$];
    arch_idx_t  want_rd;
    xlen_t      want_val;
    logic       stall_seen = 1'b0;
    int         value_errs = 0;
    int         proto_errs = 0;
    int         total_errs;
    int         cycles = 0;
    int         timeout_limit;

    backend_top dut_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .uop_valid_i    (uop_valid_i),
        .uop_ready_o    (uop_ready_o),
        .uop_op_i       (uop_op_i),
        .uop_rd_i       (uop_rd_i),
        .uop_rs1_i      (uop_rs1_i),
        .uop_rs2_i      (uop_rs2_i),
        .uop_imm_i      (uop_imm_i),
        .uop_use_imm_i  (uop_use_imm_i),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_value_o (commit_value_o)
    );

    bind backend_top backend_checker checker_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .uop_ready_i    (uop_ready_o),
        .commit_valid_i (commit_valid_o),
        .commit_rd_i    (commit_rd_o),
        .commit_value_i (commit_value_o),
        .rob_count_i    (rob_i.rob_count),
        .fl_count_i     (rename_i.fl_count)
    );

    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic xlen_t ref_alu(input alu_op_e op, input xlen_t a, input xlen_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a + ~b + 1'b1;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << sh;
            ALU_SRL: return a >> sh;
            // differing signs decide on the sign of a alone
            default: return (a[`BE_XLEN-1] != b[`BE_XLEN-1]) ? xlen_t'(a[`BE_XLEN-1])
                                                              : xlen_t'(a < b);
        endcase
    endfunction

    task automatic add_row(input alu_op_e op, input int rd, input int rs1, input int rs2,
                           input xlen_t imm, input logic use_imm, input int gap);
        xlen_t b;
        b = use_imm ? imm : arch_regs[rs2];
        row_op[n_rows]      = op;
        row_rd[n_rows]      = arch_idx_t'(rd);
        row_rs1[n_rows]     = arch_idx_t'(rs1);
        row_rs2[n_rows]     = arch_idx_t'(rs2);
        row_imm[n_rows]     = imm;
        row_use_imm[n_rows] = use_imm;
        row_gap[n_rows]     = gap;
        row_exp[n_rows]     = ref_alu(op, arch_regs[rs1], b);
        arch_regs[rd]       = row_exp[n_rows];
        n_rows++;
    endtask

    task automatic add_random_row();
        int    op;
        int    rd;
        int    rs1;
        int    rs2;
        xlen_t imm;
        logic  use_imm;
        int    gap;
        op      = $urandom_range(7, 0);
        rd      = $urandom_range(7, 0);
        rs1     = $urandom_range(7, 0);
        rs2     = $urandom_range(7, 0);
        imm     = $urandom;
        use_imm = 1'($urandom_range(1, 0));
        gap     = $urandom_range(3, 0);
        add_row(alu_op_e'(op), rd, rs1, rs2, imm, use_imm, gap);
    endtask

    task automatic build_table();
        for (int r = 0; r < `BE_ARCH_REGS; r++) begin
            arch_regs[r] = '0;
        end
        n_rows = 0;
        add_row(ALU_ADD, 1, 0, 0, 32'h1234_5678, 1'b1, 2);
        add_row(ALU_ADD, 2, 0, 0, 32'hFFFF_FFF3, 1'b1, 2);
        add_row(ALU_ADD, 3, 0, 0, 32'h0000_0004, 1'b1, 2);
        for (int k = 0; k < 8; k++) begin
            add_row(alu_op_e'(k), 4, 1, 2, '0, 1'b0, 2);
            add_row(alu_op_e'(k), 5, 2, 0, 32'h0F0F_0003, 1'b1, 2);
        end
        // back to back dependents through r6 and r7
        for (int k = 0; k < 6; k++) begin
            add_row(ALU_ADD, 6, 6, 0, xlen_t'(k + 1), 1'b1, 0);
        end
        add_row(ALU_XOR, 7, 6, 1, '0, 1'b0, 0);
        add_row(ALU_SLT, 7, 2, 7, '0, 1'b0, 4);
        // each burst row reads the one before, so the station backs up
        burst_lo = n_rows;
        for (int k = 0; k < BURST_ROWS; k++) begin
            add_row(ALU_ADD, k % 8, (k + 7) % 8, 3, '0, 1'b0, (k == BURST_ROWS - 1) ? 4 : 0);
        end
        burst_hi = n_rows - 1;
        for (int k = 0; k < RANDOM_ROWS; k++) begin
            add_random_row();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // driver, monitor and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_row(input int k);
        uop_valid_i   <= 1'b1;
        uop_op_i      <= row_op[k];
        uop_rd_i      <= row_rd[k];
        uop_rs1_i     <= row_rs1[k];
        uop_rs2_i     <= row_rs2[k];
        uop_imm_i     <= row_imm[k];
        uop_use_imm_i <= row_use_imm[k];
        @(negedge clk);
        while (!uop_ready_o) begin
            if (k >= burst_lo && k <= burst_hi) begin
                stall_seen = 1'b1;
            end
            @(negedge clk);
        end
        // the next rising edge accepts the row
        @(posedge clk);
        exp_rd_q.push_back(row_rd[k]);
        exp_val_q.push_back(row_exp[k]);
        if (row_gap[k] > 0) begin
            uop_valid_i <= 1'b0;
            repeat (row_gap[k]) @(posedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n_i && commit_valid_o) begin
            assert (exp_val_q.size() != 0) else begin
                $display("a commit of r%0d arrived at %0t with no instruction outstanding",
                         commit_rd_o, $time);
                proto_errs++;
            end
            if (exp_val_q.size() != 0) begin
                want_rd  = exp_rd_q.pop_front();
                want_val = exp_val_q.pop_front();
                assert (commit_rd_o == want_rd && commit_value_o == want_val) else begin
                    $display("ERR %0t: commit r%0d = %08h, expected r%0d = %08h", $time,
                             commit_rd_o, commit_value_o, want_rd, want_val);
                    value_errs++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("run stopped after %0d cycles with %0d instructions still outstanding",
                     cycles, exp_val_q.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        rst_n_i       = 1'b0;
        uop_valid_i   = 1'b0;
        uop_op_i      = ALU_ADD;
        uop_rd_i      = '0;
        uop_rs1_i     = '0;
        uop_rs2_i     = '0;
        uop_imm_i     = '0;
        uop_use_imm_i = 1'b0;
        build_table();
        timeout_limit = n_rows * CYCLES_PER_ROW + TIMEOUT_MARGIN;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        assert (!commit_valid_o && uop_ready_o) else begin
            $display("ERR %0t: after reset commit_valid_o=%b uop_ready_o=%b, expected 0 and 1",
                     $time, commit_valid_o, uop_ready_o);
            value_errs++;
        end
        @(posedge clk);
        for (int k = 0; k < n_rows; k++) begin
            drive_row(k);
        end
        uop_valid_i <= 1'b0;
        while (exp_val_q.size() != 0) begin
            @(posedge clk);
        end
        // a few idle cycles to catch a stray commit
        repeat (10) @(posedge clk);
        assert (stall_seen) else begin
            $display("uop_ready_o never dropped during the dependent burst");
            proto_errs++;
        end
        total_errs = value_errs + proto_errs + dut_i.checker_i.fail_count;
        $display("errors: %0d value, %0d protocol, %0d assertion", value_errs, proto_errs,
                 dut_i.checker_i.fail_count);
        if (total_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
design/uop_pkg.sv
design/rename_pkg.sv
design/rename_stage.sv
design/rob.sv
design/int_rs.sv
design/prf.sv
design/backend_top.sv
sim/backend_checker.sv
sim/backend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the backend testbench with Verilator and run it
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module backend_tb \
    -f compile.f -o backend_sim
./obj_dir/backend_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
grep -q "Simulation PASSED" sim.log
